// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_sdio_burst_reader
FILELIST  = sdio_burst_reader.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== bench/sd_card_model.sv ====
/*
  behavioral SD card
  decodes commands with a CRC7 check, logs them, answers with short
  responses and streams patterned 4-bit sectors after CMD18
*/
`timescale 1ns/100ps
`default_nettype none

module sd_card_model (
  input  wire        sdclk_i,
  input  wire        cmd_i,     // resolved cmd line
  output logic       cmd_o,
  output logic       cmd_oe_o,
  output logic [3:0] dat_o,
  output logic       busy_o     // response in progress
);

  logic [47:0] rx_frame;
  logic [47:0] tx_frame;
  logic [5:0]  idx_log [64];    // command index per received command
  logic [31:0] arg_log [64];
  int          cmd_count;
  int          crc_err;
  logic        cmd8_seen;
  logic        acmd41_seen;
  int          go_cnt;          // bumped per CMD18, read by the data side
  int          stop_cnt;        // bumped per CMD12
  logic [19:0] go_addr;
  int          go_seen = 0;
  int          stop_seen = 0;
  logic [19:0] rd_addr;
  logic [1:0]  ds_state = 2'd0; // 0 idle, 1 payload, 2 tail or gap
  int          ds_cnt;
  logic [3:0]  dat_q = 4'hF;

  assign dat_o = dat_q;

  // x^7 + x^3 + 1 over 40 bits, msb first
  function automatic logic [6:0] crc7_of(input logic [39:0] bits);
    logic [6:0] crc;
    logic       fb;
    crc = '0;
    for (int i = 39; i >= 0; i--) begin
      fb  = crc[6] ^ bits[i];
      crc = {crc[5:0], 1'b0};
      if (fb) crc = crc ^ 7'h09;
    end
    return crc;
  endfunction

  // byte b of sector a is (a*7 + b) mod 256, upper nibble first
  function automatic logic [3:0] nibble_of(input logic [19:0] addr, input int c);
    logic [7:0] val;
    val = 8'((int'(addr) * 7 + c / 2) % 256);
    return (c % 2 == 0) ? val[7:4] : val[3:0];
  endfunction

  task automatic receive_cmd();
    do @(posedge sdclk_i); while (cmd_i !== 1'b0);  // start bit
    rx_frame[47] = 1'b0;
    for (int i = 46; i >= 0; i--) begin
      @(posedge sdclk_i);
      rx_frame[i] = cmd_i;
    end
  endtask

  task automatic send_resp(input logic [5:0] idx, input logic [31:0] payload);
    tx_frame      = {2'b00, idx, payload, 8'h01};
    tx_frame[7:1] = crc7_of(tx_frame[47:8]);
    busy_o = 1'b1;
    repeat (2) @(negedge sdclk_i);  // host releases the line first
    for (int i = 47; i >= 0; i--) begin
      @(negedge sdclk_i);
      cmd_oe_o = 1'b1;
      cmd_o    = tx_frame[i];
    end
    @(negedge sdclk_i);
    cmd_oe_o = 1'b0;
    cmd_o    = 1'b1;
    busy_o   = 1'b0;
  endtask

  initial begin
    cmd_o = 1'b1;
    cmd_oe_o = 1'b0;
    busy_o = 1'b0;
    cmd_count = 0;
    crc_err = 0;
    cmd8_seen = 1'b0;
    acmd41_seen = 1'b0;
    go_cnt = 0;
    stop_cnt = 0;
    go_addr = '0;
    forever begin
      receive_cmd();
      if (crc7_of(rx_frame[47:8]) != rx_frame[7:1]) crc_err++;
      idx_log[cmd_count] = rx_frame[45:40];
      arg_log[cmd_count] = rx_frame[39:8];
      cmd_count++;
      case (rx_frame[45:40])
        6'd0: ;  // go idle has no answer
        6'd8: begin
          if (!cmd8_seen) cmd8_seen = 1'b1;  // first one lost, host must retry
          else send_resp(6'd8, {20'h0, rx_frame[19:8]});  // echo voltage and pattern
        end
        6'd55: send_resp(6'd55, 32'h0000_0120);
        6'd41: begin
          send_resp(6'd63, acmd41_seen ? 32'hC0FF_8000 : 32'h00FF_8000);  // busy once
          acmd41_seen = 1'b1;
        end
        6'd3: send_resp(6'd3, 32'h1234_0500);  // rca 1234
        6'd18: begin
          go_addr <= rx_frame[27:8];
          send_resp(6'd18, 32'h0000_0900);
          go_cnt <= go_cnt + 1;  // data side sees it on a later fall
        end
        6'd12: begin
          stop_cnt <= stop_cnt + 1;
          send_resp(6'd12, 32'h0000_0B00);
        end
        default: send_resp(rx_frame[45:40], 32'h0000_0900);
      endcase
    end
  end

  // data lines change on falling bus edges
  always @(negedge sdclk_i) begin
    if (stop_cnt != stop_seen) begin
      stop_seen <= stop_cnt;
      ds_state  <= 2'd0;
      dat_q     <= 4'hF;
    end else begin
      case (ds_state)
        2'd0: begin
          if (go_cnt != go_seen) begin
            go_seen  <= go_cnt;
            rd_addr  <= go_addr;
            ds_state <= 2'd2;
            ds_cnt   <= 20;  // short gap before the first sector
          end
        end
        2'd1: begin
          dat_q <= nibble_of(rd_addr, ds_cnt);
          if (ds_cnt == 1023) begin
            ds_state <= 2'd2;
            ds_cnt   <= 0;
            rd_addr  <= rd_addr + 20'd1;
          end else begin
            ds_cnt <= ds_cnt + 1;
          end
        end
        default: begin
          ds_cnt <= ds_cnt + 1;
          if (ds_cnt + 1 <= 16) dat_q <= 4'h0;  // crc16 field, not checked by host
          else if (ds_cnt + 1 == 24) begin
            dat_q    <= 4'h0;  // start bit of next sector
            ds_state <= 2'd1;
            ds_cnt   <= 0;
          end else dat_q <= 4'hF;  // end bit then idle high
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== bench/tb_sdio_burst_reader.sv ====
/*
  testbench for the SDIO burst reader
  runs init against the card model, then a table of read runs with buffer checks
*/
`timescale 1ns/100ps
`default_nettype none

module tb_sdio_burst_reader;

  localparam int ROWS = 4;

  logic        clk_100mhz;
  logic        reset_ah;
  logic        start_i;
  logic [19:0] sector_pos_i;
  logic [19:0] sector_count_i;
  sd_bus_pkg::buf_addr_t buf_addr_i;
  wire  [63:0] buf_data_o;
  wire         init_done_o, sector_done_o, run_done_o;
  wire         sdclk_o, cmd_o, cmd_oe_o;
  wire         card_cmd, card_cmd_oe, card_busy;
  wire  [3:0]  card_dat;
  wire         cmd_line;
  int          errors, checks, sector_cnt, run_cnt;
  logic        timed_out;
  integer      seed;
  logic [19:0] pos_tab [ROWS];
  logic [19:0] cnt_tab [ROWS];
  int          reads_tab [ROWS];
  int          init_order [11] = '{0, 8, 8, 55, 41, 55, 41, 3, 7, 55, 6};
  int          base_log, base_sec, base_run, err_before;

  // host drives when enabled and otherwise the card or the pull-up
  assign cmd_line = cmd_oe_o ? cmd_o : (card_cmd_oe ? card_cmd : 1'b1);

  sdio_burst_reader #(
    .CLK_DIV_SLOW(4), .CLK_DIV_FAST(2), .RESP_TIMEOUT(64), .DATA_TIMEOUT(400)
  ) dut0 (
    .clk_100mhz, .reset_ah, .start_i, .sector_pos_i, .sector_count_i,
    .buf_addr_i, .buf_data_o, .init_done_o, .sector_done_o, .run_done_o,
    .sdclk_o, .cmd_o, .cmd_oe_o, .cmd_i(cmd_line), .dat_i(card_dat)
  );

  sd_card_model card0 (
    .sdclk_i(sdclk_o), .cmd_i(cmd_line), .cmd_o(card_cmd), .cmd_oe_o(card_cmd_oe),
    .dat_o(card_dat), .busy_o(card_busy)
  );

  initial begin
    clk_100mhz = 1'b0;
    forever #5 clk_100mhz = ~clk_100mhz;
  end

  always @(negedge clk_100mhz) begin  // pulse counters
    if (reset_ah) begin
      sector_cnt <= 0;
      run_cnt    <= 0;
    end else begin
      if (sector_done_o) sector_cnt <= sector_cnt + 1;
      if (run_done_o) run_cnt <= run_cnt + 1;
    end
  end

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  function automatic logic cond_met(input int which, input int target);
    case (which)
      0: return init_done_o === 1'b1;
      1: return sector_done_o === 1'b1;
      2: return run_cnt >= target;
      default: return card0.cmd_count >= target && card_busy === 1'b0;
    endcase
  endfunction

  task automatic wait_for(input int which, input int target, input int limit, input string what);
    int n;
    n = 0;
    if (timed_out) return;
    @(negedge clk_100mhz);
    while (!cond_met(which, target) && n < limit) begin
      @(negedge clk_100mhz);
      n++;
    end
    if (!cond_met(which, target)) begin
      timed_out = 1'b1;
      errors++;
      $display("timeout while waiting for %s", what);
    end
  endtask

  task automatic pulse_start();
    @(negedge clk_100mhz);
    start_i = 1'b1;
    @(negedge clk_100mhz);
    start_i = 1'b0;
  endtask

  // one word per cycle with data one cycle behind its address
  task automatic read_sector(input logic [19:0] addr);
    logic [63:0] exp;
    for (int w = 0; w < 64; w++) begin
      buf_addr_i = 6'(w);
      @(negedge clk_100mhz);
      for (int k = 0; k < 8; k++) exp[8*k +: 8] = 8'((int'(addr) * 7 + w * 8 + k) % 256);
      check_value($sformatf("buf_data_o[%0d] sector %0d", w, addr), buf_data_o, exp);
    end
  endtask

  initial begin
    reset_ah = 1'b1;
    start_i = 1'b0;
    sector_pos_i = '0;
    sector_count_i = '0;
    buf_addr_i = '0;
    errors = 0;
    checks = 0;
    timed_out = 1'b0;
    seed = 32'h2692;
    pos_tab[0] = 20'd5;
    cnt_tab[0] = 20'd2;
    reads_tab[0] = 2;
    pos_tab[1] = 20'($unsigned($random(seed)) % 50000);
    cnt_tab[1] = 20'd1;
    reads_tab[1] = 1;
    pos_tab[2] = 20'd300;
    cnt_tab[2] = 20'd3;
    reads_tab[2] = 3;
    pos_tab[3] = 20'd9;  // empty run
    cnt_tab[3] = 20'd0;
    reads_tab[3] = 0;
    repeat (4) @(posedge clk_100mhz);
    @(negedge clk_100mhz);
    reset_ah = 1'b0;

    pulse_start();
    wait_for(0, 0, 100000, "init_done_o");
    wait_for(3, 11, 2000, "the last init response");
    check_value("init command count", card0.cmd_count, 11);
    for (int i = 0; i < 11; i++) begin
      check_value($sformatf("init cmd %0d index", i), card0.idx_log[i], init_order[i]);
    end
    check_value("crc7 mismatches", card0.crc_err, 0);
    check_value("CMD7 rca", card0.arg_log[8][31:16], 16'h1234);
    check_value("CMD55 rca", card0.arg_log[9][31:16], 16'h1234);
    check_value("ACMD6 arg", card0.arg_log[10], 32'h2);  // bus width 4
    $display("test init: %s", (errors == 0) ? "ok" : "FAIL");

    for (int r = 0; r < ROWS && !timed_out; r++) begin
      base_log = card0.cmd_count;
      base_sec = sector_cnt;
      base_run = run_cnt;
      err_before = errors;
      sector_pos_i = pos_tab[r];
      sector_count_i = cnt_tab[r];
      pulse_start();
      if (reads_tab[r] == 0) begin
        repeat (3000) @(negedge clk_100mhz);  // nothing may happen here
        check_value("commands after empty start", card0.cmd_count, base_log);
      end else begin
        for (int s = 0; s < reads_tab[r] && !timed_out; s++) begin
          wait_for(1, 0, 20000, "sector_done_o");
          if (!timed_out) read_sector(pos_tab[r] + 20'(s));
        end
        wait_for(2, base_run + 1, 20000, "run_done_o");
        wait_for(3, base_log + 2, 20000, "the CMD12 response");
        check_value("CMD18 index", card0.idx_log[base_log], 18);
        check_value("CMD18 arg", card0.arg_log[base_log], {12'h0, pos_tab[r]});
        check_value("CMD12 index", card0.idx_log[base_log + 1], 12);
      end
      repeat (20) @(negedge clk_100mhz);
      check_value("sector_done_o pulses", sector_cnt - base_sec, reads_tab[r]);
      check_value("run_done_o pulses", run_cnt - base_run, (reads_tab[r] == 0) ? 0 : 1);
      $display("test row %0d pos %0d count %0d: %s", r, pos_tab[r], cnt_tab[r],
               (errors == err_before) ? "ok" : "FAIL");
    end

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/sd_bus_pkg.sv ====
/*
  SD bus sizes and framing
  shared by the bus clock, command engine and sector receiver
*/
`default_nettype none

package sd_bus_pkg;

  localparam int CMD_FRAME_BITS    = 48;    // command or short response on the cmd line
  localparam int RESP_PAYLOAD_BITS = 47;    // response bits kept after the start bit
  localparam int CMD_PAD_CLKS      = 4;     // idle bus clocks ahead of every command

  localparam int SECTOR_WORDS      = 64;    // 512 bytes / 8 bytes per word
  localparam int WORD_BITS         = 64;
  localparam int SECTOR_NIBBLES    = 1024;  // 4-bit bus so two clocks per byte
  localparam int DATA_TAIL_CLKS    = 21;    // crc16 + end bit + 4 clocks of slack

  typedef logic [5:0] buf_addr_t;           // word index into the sector buffer

endpackage

`default_nettype wire

// ==== logic/sd_card_sequencer.sv ====
/*
  SD card sequencer
  walks the SDHC init order, then runs multi-sector reads with CMD18,
  retries lost responses or data starts and closes each run with CMD12
*/
`timescale 1ns/100ps
`default_nettype none

module sd_card_sequencer (
  input  wire         clk_100mhz,
  input  wire         reset_ah,
  input  wire         start_i,
  input  wire  [19:0] sector_pos_i,
  input  wire  [19:0] sector_count_i,
  input  wire         cmd_done_i,
  input  wire         resp_ok_i,
  input  wire  [sd_bus_pkg::RESP_PAYLOAD_BITS-1:0] resp_bits_i,
  input  wire         data_done_i,
  input  wire         data_ok_i,
  output logic        cmd_start_o,
  output logic [5:0]  cmd_index_o,
  output logic [31:0] cmd_arg_o,
  output logic        data_start_o,
  output logic        fast_o,
  output logic        init_done_o,
  output logic        run_done_o
);

  sd_cmd_pkg::seq_state_t state_q;
  sd_cmd_pkg::seq_state_t nxt_state;  // where a finished command leads
  logic        pend_q;    // command or sector handed off, waiting for done
  logic [15:0] rca_q;
  logic [19:0] pos_q;
  logic [19:0] count_q;
  logic [19:0] offset_q;  // sectors already read in this run

  always_comb begin
    cmd_index_o = sd_cmd_pkg::CMD_GO_IDLE;
    cmd_arg_o   = '0;
    nxt_state   = state_q;
    case (state_q)
      sd_cmd_pkg::SEQ_CMD0: begin
        nxt_state = sd_cmd_pkg::SEQ_CMD8;  // no response to check
      end
      sd_cmd_pkg::SEQ_CMD8: begin
        cmd_index_o = sd_cmd_pkg::CMD_SEND_IF_COND;
        cmd_arg_o   = sd_cmd_pkg::ARG_IF_COND;
        if (resp_ok_i && resp_bits_i[15:8] == sd_cmd_pkg::CHECK_PATTERN) begin
          nxt_state = sd_cmd_pkg::SEQ_APP41;
        end
      end
      sd_cmd_pkg::SEQ_APP41: begin
        cmd_index_o = sd_cmd_pkg::CMD_APP;  // rca still 0 here
        if (resp_ok_i) nxt_state = sd_cmd_pkg::SEQ_ACMD41;
      end
      sd_cmd_pkg::SEQ_ACMD41: begin
        cmd_index_o = sd_cmd_pkg::ACMD_OP_COND;
        cmd_arg_o   = sd_cmd_pkg::ARG_OP_COND;
        nxt_state   = sd_cmd_pkg::SEQ_APP41;  // still powering up
        if (resp_ok_i && resp_bits_i[sd_cmd_pkg::OCR_READY_BIT]) begin
          nxt_state = sd_cmd_pkg::SEQ_CMD3;
        end
      end
      sd_cmd_pkg::SEQ_CMD3: begin
        cmd_index_o = sd_cmd_pkg::CMD_SEND_RCA;
        if (resp_ok_i) nxt_state = sd_cmd_pkg::SEQ_CMD7;
      end
      sd_cmd_pkg::SEQ_CMD7: begin
        cmd_index_o = sd_cmd_pkg::CMD_SELECT;
        cmd_arg_o   = {rca_q, 16'h0};
        if (resp_ok_i) nxt_state = sd_cmd_pkg::SEQ_APP6;
      end
      sd_cmd_pkg::SEQ_APP6: begin
        cmd_index_o = sd_cmd_pkg::CMD_APP;
        cmd_arg_o   = {rca_q, 16'h0};
        if (resp_ok_i) nxt_state = sd_cmd_pkg::SEQ_ACMD6;
      end
      sd_cmd_pkg::SEQ_ACMD6: begin
        cmd_index_o = sd_cmd_pkg::ACMD_BUS_WIDTH;
        cmd_arg_o   = sd_cmd_pkg::ARG_BUS4;
        nxt_state   = resp_ok_i ? sd_cmd_pkg::SEQ_READY : sd_cmd_pkg::SEQ_APP6;
      end
      sd_cmd_pkg::SEQ_CMD18: begin
        cmd_index_o = sd_cmd_pkg::CMD_READ_MULTI;
        cmd_arg_o   = {12'h0, pos_q + offset_q};  // SDHC block address
        if (resp_ok_i) nxt_state = sd_cmd_pkg::SEQ_DATA;
      end
      sd_cmd_pkg::SEQ_CMD12: begin
        cmd_index_o = sd_cmd_pkg::CMD_STOP;
        if (resp_ok_i) nxt_state = sd_cmd_pkg::SEQ_READY;
      end
      default: begin
        nxt_state = state_q;
      end
    endcase
  end

  always_ff @(posedge clk_100mhz) begin
    if (reset_ah) begin
      state_q      <= sd_cmd_pkg::SEQ_IDLE;
      pend_q       <= 1'b0;
      cmd_start_o  <= 1'b0;
      data_start_o <= 1'b0;
      fast_o       <= 1'b0;
      init_done_o  <= 1'b0;
      run_done_o   <= 1'b0;
      offset_q     <= '0;
    end else begin
      cmd_start_o  <= 1'b0;
      data_start_o <= 1'b0;
      run_done_o   <= 1'b0;
      case (state_q)
        sd_cmd_pkg::SEQ_IDLE: begin
          if (start_i) state_q <= sd_cmd_pkg::SEQ_CMD0;
        end
        sd_cmd_pkg::SEQ_READY: begin
          if (start_i && sector_count_i != '0) begin  // empty runs are dropped
            pos_q   <= sector_pos_i;
            count_q <= sector_count_i;
            state_q <= sd_cmd_pkg::SEQ_CMD18;
          end
        end
        sd_cmd_pkg::SEQ_DATA: begin
          if (!pend_q) begin
            data_start_o <= 1'b1;
            pend_q       <= 1'b1;
          end else if (data_done_i) begin
            pend_q <= 1'b0;
            if (!data_ok_i) begin
              state_q <= sd_cmd_pkg::SEQ_CMD18;  // no start bit, reissue at current offset
            end else begin
              offset_q <= offset_q + 20'd1;
              if (offset_q + 20'd1 == count_q) state_q <= sd_cmd_pkg::SEQ_CMD12;
            end
          end
        end
        default: begin  // one command in flight at a time
          if (!pend_q) begin
            cmd_start_o <= 1'b1;
            pend_q      <= 1'b1;
            if (state_q == sd_cmd_pkg::SEQ_CMD12) begin
              run_done_o <= (offset_q != '0);  // a CMD12 retry finds it cleared
              offset_q   <= '0;
            end
          end else if (cmd_done_i) begin
            pend_q  <= 1'b0;
            state_q <= nxt_state;
            if (state_q == sd_cmd_pkg::SEQ_CMD3 && resp_ok_i) begin
              rca_q <= resp_bits_i[sd_cmd_pkg::RCA_MSB -: 16];
            end
            if (state_q == sd_cmd_pkg::SEQ_CMD7 && resp_ok_i) fast_o <= 1'b1;  // card selected
            if (state_q == sd_cmd_pkg::SEQ_ACMD6 && resp_ok_i) init_done_o <= 1'b1;
          end
        end
      endcase
    end
  end

  // sector requests only come from the data phase and never with a command
  assert property (@(posedge clk_100mhz) disable iff (reset_ah)
    data_start_o |-> !cmd_start_o && state_q == sd_cmd_pkg::SEQ_DATA);

endmodule

`default_nettype wire

// ==== logic/sd_clock_gen.sv ====
/*
  SD bus clock divider
  toggles sdclk while a user is busy and strobes each edge one cycle early
*/
`timescale 1ns/100ps
`default_nettype none

module sd_clock_gen #(
  parameter int unsigned CLK_DIV_SLOW = 125,  // half-period in system clocks
  parameter int unsigned CLK_DIV_FAST = 2
) (
  input  wire  clk_100mhz,
  input  wire  reset_ah,
  input  wire  run_i,
  input  wire  fast_i,
  output logic sdclk_o,
  output logic rise_o,
  output logic fall_o
);

  localparam int CNT_W = $clog2(CLK_DIV_SLOW + 1);

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] half_m1;
  logic             tick;

  assign half_m1 = fast_i ? CNT_W'(CLK_DIV_FAST - 1) : CNT_W'(CLK_DIV_SLOW - 1);
  assign tick    = (run_i || sdclk_o) && (cnt_q >= half_m1);  // a high phase always completes
  assign rise_o  = tick && !sdclk_o;
  assign fall_o  = tick && sdclk_o;

  always_ff @(posedge clk_100mhz) begin
    if (reset_ah) begin
      cnt_q    <= '0;
      sdclk_o  <= 1'b0;
    end else if (tick) begin
      cnt_q    <= '0;
      sdclk_o  <= !sdclk_o;
    end else if (run_i || sdclk_o) begin
      cnt_q    <= cnt_q + 1'b1;
    end else begin
      cnt_q    <= '0;  // parked low
    end
  end

  // an edge strobe is exclusive and the pin follows it next cycle
  assert property (@(posedge clk_100mhz) disable iff (reset_ah)
    rise_o |-> !fall_o ##1 sdclk_o);

endmodule

`default_nettype wire

// ==== logic/sd_cmd_engine.sv ====
/*
  SD command engine
  pads, sends a 48-bit command with serial CRC7 on falling edges,
  then samples a 47-bit response on rising edges with a timeout
*/
`timescale 1ns/100ps
`default_nettype none

module sd_cmd_engine #(
  parameter int unsigned RESP_TIMEOUT = 64  // bus clocks to wait for a start bit
) (
  input  wire         clk_100mhz,
  input  wire         reset_ah,
  input  wire         cmd_start_i,
  input  wire  [5:0]  cmd_index_i,
  input  wire  [31:0] cmd_arg_i,
  input  wire         rise_i,
  input  wire         fall_i,
  input  wire         cmd_i,
  output logic        busy_o,
  output logic        cmd_o,
  output logic        cmd_oe_o,
  output logic        cmd_done_o,
  output logic        resp_ok_o,
  output logic [sd_bus_pkg::RESP_PAYLOAD_BITS-1:0] resp_bits_o
);

  localparam int         WAIT_W    = $clog2(RESP_TIMEOUT + 1);
  localparam logic [6:0] TX_FIRST  = 7'(sd_bus_pkg::CMD_PAD_CLKS);  // fall that drives start bit
  localparam logic [6:0] TX_END    = 7'(sd_bus_pkg::CMD_PAD_CLKS + sd_bus_pkg::CMD_FRAME_BITS);
  localparam logic [6:0] CRC_FIRST = TX_END - 7'd8;  // crc7 then end bit
  localparam logic [5:0] RESP_LAST = 6'(sd_bus_pkg::RESP_PAYLOAD_BITS - 1);

  typedef enum logic [1:0] {E_IDLE, E_TX, E_WAIT, E_RESP} eng_state_t;

  eng_state_t        state_q;
  logic [6:0]        tx_cnt_q;   // falls since cmd_start
  logic [39:0]       frame_q;    // start, dir, index, arg
  logic [6:0]        crc_q;
  logic              no_resp_q;  // CMD0 gets no answer
  logic [WAIT_W-1:0] wait_cnt_q;
  logic [5:0]        resp_cnt_q;

  function automatic logic [6:0] crc7_step(input logic [6:0] crc, input logic din);
    logic fb;
    fb = crc[6] ^ din;
    return {crc[5:0], fb} ^ {3'b000, fb, 3'b000};  // x^7 + x^3 + 1
  endfunction

  assign busy_o = (state_q != E_IDLE);

  always_ff @(posedge clk_100mhz) begin
    if (reset_ah) begin
      state_q    <= E_IDLE;
      cmd_o      <= 1'b1;
      cmd_oe_o   <= 1'b0;
      cmd_done_o <= 1'b0;
      resp_ok_o  <= 1'b0;
      tx_cnt_q   <= '0;
      crc_q      <= '0;
      wait_cnt_q <= '0;
      resp_cnt_q <= '0;
    end else begin
      cmd_done_o <= 1'b0;
      case (state_q)
        E_IDLE: begin
          if (cmd_start_i) begin
            state_q  <= E_TX;
            tx_cnt_q <= '0;
            crc_q    <= '0;
          end
        end
        E_TX: begin
          if (fall_i) begin
            tx_cnt_q <= tx_cnt_q + 1'b1;
            if (tx_cnt_q == TX_END) begin  // end bit held a full clock, let go of the line
              cmd_oe_o <= 1'b0;
              if (no_resp_q) begin
                state_q    <= E_IDLE;
                cmd_done_o <= 1'b1;
                resp_ok_o  <= 1'b1;
              end else begin
                state_q    <= E_WAIT;
                wait_cnt_q <= '0;
              end
            end else if (tx_cnt_q >= TX_FIRST) begin
              cmd_oe_o <= 1'b1;
              if (tx_cnt_q < CRC_FIRST) begin
                cmd_o <= frame_q[39];
                crc_q <= crc7_step(crc_q, frame_q[39]);
              end else if (tx_cnt_q < TX_END - 7'd1) begin
                cmd_o <= crc_q[6];  // crc shifted out msb first
                crc_q <= {crc_q[5:0], 1'b0};
              end else begin
                cmd_o <= 1'b1;      // end bit
              end
            end
          end
        end
        E_WAIT: begin
          if (rise_i) begin
            if (!cmd_i) begin
              state_q    <= E_RESP;  // start bit seen
              resp_cnt_q <= '0;
            end else if (wait_cnt_q == WAIT_W'(RESP_TIMEOUT - 1)) begin
              state_q    <= E_IDLE;
              cmd_done_o <= 1'b1;
              resp_ok_o  <= 1'b0;
            end else begin
              wait_cnt_q <= wait_cnt_q + 1'b1;
            end
          end
        end
        default: begin  // E_RESP
          if (rise_i) begin
            resp_cnt_q <= resp_cnt_q + 1'b1;
            if (resp_cnt_q == RESP_LAST) begin
              state_q    <= E_IDLE;
              cmd_done_o <= 1'b1;
              resp_ok_o  <= 1'b1;
            end
          end
        end
      endcase
    end
  end

  // frame and response shifters carry no reset
  always_ff @(posedge clk_100mhz) begin
    if (state_q == E_IDLE && cmd_start_i) begin
      frame_q   <= {2'b01, cmd_index_i, cmd_arg_i};
      no_resp_q <= (cmd_index_i == sd_cmd_pkg::CMD_GO_IDLE);
    end else if (state_q == E_TX && fall_i && tx_cnt_q >= TX_FIRST) begin
      frame_q   <= {frame_q[38:0], 1'b0};
    end
    if (state_q == E_RESP && rise_i) begin
      resp_bits_o <= {resp_bits_o[sd_bus_pkg::RESP_PAYLOAD_BITS-2:0], cmd_i};  // msb first
    end
  end

  // the card owns the line from the end of the command until cmd_done
  assert property (@(posedge clk_100mhz) disable iff (reset_ah)
    (state_q == E_WAIT || state_q == E_RESP) |-> !cmd_oe_o);

endmodule

`default_nettype wire

// ==== logic/sd_cmd_pkg.sv ====
/*
  SD command set used by the host
  indices, fixed arguments, response fields and sequencer states
*/
`default_nettype none

package sd_cmd_pkg;

  localparam logic [5:0] CMD_GO_IDLE     = 6'd0;
  localparam logic [5:0] CMD_SEND_IF_COND = 6'd8;
  localparam logic [5:0] CMD_APP         = 6'd55;  // prefix for app commands
  localparam logic [5:0] ACMD_OP_COND    = 6'd41;
  localparam logic [5:0] CMD_SEND_RCA    = 6'd3;
  localparam logic [5:0] CMD_SELECT      = 6'd7;
  localparam logic [5:0] ACMD_BUS_WIDTH  = 6'd6;
  localparam logic [5:0] CMD_READ_MULTI  = 6'd18;
  localparam logic [5:0] CMD_STOP        = 6'd12;

  localparam logic [7:0]  CHECK_PATTERN = 8'hAA;
  localparam logic [31:0] ARG_IF_COND   = {20'h0, 4'h1, CHECK_PATTERN};  // 2.7-3.6V
  localparam logic [31:0] ARG_OP_COND   = 32'h4010_0000;  // HCS set, 3.2-3.3V window
  localparam logic [31:0] ARG_BUS4      = 32'h0000_0002;  // bus width code 2'b10

  // positions inside the 47 captured response bits, payload is [39:8]
  localparam int OCR_READY_BIT = 39;  // OCR bit 31, power-up done
  localparam int RCA_MSB       = 39;  // new RCA sits in R6 [39:24]

  typedef enum logic [3:0] {
    SEQ_IDLE,
    SEQ_CMD0,
    SEQ_CMD8,
    SEQ_APP41,
    SEQ_ACMD41,
    SEQ_CMD3,
    SEQ_CMD7,
    SEQ_APP6,
    SEQ_ACMD6,
    SEQ_READY,   // card in transfer state, waiting for a run
    SEQ_CMD18,
    SEQ_DATA,
    SEQ_CMD12
  } seq_state_t;

endpackage

`default_nettype wire

// ==== logic/sd_sector_rx.sv ====
/*
  SD sector receiver
  finds the data start bit on dat[0], packs 1024 nibbles into 64-bit
  words of the sector buffer and skips the crc16 tail
*/
`timescale 1ns/100ps
`default_nettype none

module sd_sector_rx #(
  parameter int unsigned DATA_TIMEOUT = 50000  // bus clocks to wait for a start bit
) (
  input  wire         clk_100mhz,
  input  wire         reset_ah,
  input  wire         data_start_i,
  input  wire         rise_i,
  input  wire         fall_i,
  input  wire  [3:0]  dat_i,
  input  wire  sd_bus_pkg::buf_addr_t buf_addr_i,
  output logic        busy_o,
  output logic        data_done_o,
  output logic        data_ok_o,
  output logic        sector_done_o,
  output logic [sd_bus_pkg::WORD_BITS-1:0] buf_data_o
);

  localparam int         WAIT_W    = $clog2(DATA_TIMEOUT + 1);
  localparam logic [9:0] NIB_LAST  = 10'(sd_bus_pkg::SECTOR_NIBBLES - 1);
  localparam logic [4:0] TAIL_LAST = 5'(sd_bus_pkg::DATA_TAIL_CLKS - 1);

  typedef enum logic [1:0] {R_IDLE, R_WAIT, R_DATA, R_TAIL} rx_state_t;

  rx_state_t         state_q;
  logic [WAIT_W-1:0] wait_cnt_q;
  logic [9:0]        nib_cnt_q;   // word index in [9:4] and nibble in [3:0]
  logic [4:0]        tail_cnt_q;
  logic [5:0]        lane;        // lowest bit of the nibble in its word
  logic              nib_en;
  logic              wr_en;
  logic [sd_bus_pkg::WORD_BITS-1:0] word_q;
  logic [sd_bus_pkg::WORD_BITS-1:0] buf_mem [sd_bus_pkg::SECTOR_WORDS];

  // byte k of a word sits at bit 8k with its upper nibble first
  assign lane   = {nib_cnt_q[3:1], !nib_cnt_q[0], 2'b00};
  assign nib_en = (state_q == R_DATA) && rise_i;
  assign wr_en  = nib_en && (nib_cnt_q[3:0] == 4'hF);
  assign busy_o = (state_q != R_IDLE);

  always_ff @(posedge clk_100mhz) begin
    if (reset_ah) begin
      state_q       <= R_IDLE;
      data_done_o   <= 1'b0;
      data_ok_o     <= 1'b0;
      sector_done_o <= 1'b0;
      wait_cnt_q    <= '0;
      nib_cnt_q     <= '0;
      tail_cnt_q    <= '0;
    end else begin
      data_done_o   <= 1'b0;
      sector_done_o <= wr_en && (nib_cnt_q == NIB_LAST);  // one cycle after the last write
      case (state_q)
        R_IDLE: begin
          if (data_start_i) begin
            state_q    <= R_WAIT;
            wait_cnt_q <= '0;
          end
        end
        R_WAIT: begin
          if (rise_i) begin
            if (!dat_i[0]) begin
              state_q   <= R_DATA;
              nib_cnt_q <= '0;
            end else if (wait_cnt_q == WAIT_W'(DATA_TIMEOUT - 1)) begin
              state_q     <= R_IDLE;  // card never started so the sequencer retries
              data_done_o <= 1'b1;
              data_ok_o   <= 1'b0;
            end else begin
              wait_cnt_q <= wait_cnt_q + 1'b1;
            end
          end
        end
        R_DATA: begin
          if (rise_i) begin
            nib_cnt_q <= nib_cnt_q + 1'b1;
            if (nib_cnt_q == NIB_LAST) begin
              state_q    <= R_TAIL;
              tail_cnt_q <= '0;
            end
          end
        end
        default: begin  // R_TAIL counts falls so the clock ends low
          if (fall_i) begin
            tail_cnt_q <= tail_cnt_q + 1'b1;
            if (tail_cnt_q == TAIL_LAST) begin
              state_q     <= R_IDLE;
              data_done_o <= 1'b1;
              data_ok_o   <= 1'b1;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (wr_en) begin  // 16th nibble goes straight into the memory word
      buf_mem[nib_cnt_q[9:4]] <= {word_q[63:60], dat_i, word_q[55:0]};
    end else if (nib_en) begin
      word_q[lane +: 4] <= dat_i;
    end
    buf_data_o <= buf_mem[buf_addr_i];  // registered read port
  end

  // a buffer write keeps the payload open, only the last word closes it with sector_done
  assert property (@(posedge clk_100mhz) disable iff (reset_ah)
    wr_en |=> (state_q == R_DATA) || (state_q == R_TAIL && sector_done_o));

endmodule

`default_nettype wire

// ==== logic/sdio_burst_reader.sv ====
/*
  SDIO burst reader top
  4-bit SD host for SDHC cards with a 64 x 64-bit sector buffer
*/
`timescale 1ns/100ps
`default_nettype none

module sdio_burst_reader #(
  parameter int unsigned CLK_DIV_SLOW = 125,   // 400 kHz during identification
  parameter int unsigned CLK_DIV_FAST = 2,     // 25 MHz after select
  parameter int unsigned RESP_TIMEOUT = 64,
  parameter int unsigned DATA_TIMEOUT = 50000
) (
  input  wire         clk_100mhz,
  input  wire         reset_ah,
  input  wire         start_i,
  input  wire  [19:0] sector_pos_i,
  input  wire  [19:0] sector_count_i,
  input  wire  sd_bus_pkg::buf_addr_t buf_addr_i,
  output logic [sd_bus_pkg::WORD_BITS-1:0] buf_data_o,
  output logic        init_done_o,
  output logic        sector_done_o,
  output logic        run_done_o,
  output logic        sdclk_o,
  output logic        cmd_o,
  output logic        cmd_oe_o,
  input  wire         cmd_i,
  input  wire  [3:0]  dat_i
);

  logic        cmd_start;
  logic [5:0]  cmd_index;
  logic [31:0] cmd_arg;
  logic        cmd_done;
  logic        resp_ok;
  logic [sd_bus_pkg::RESP_PAYLOAD_BITS-1:0] resp_bits;
  logic        data_start;
  logic        data_done;
  logic        data_ok;
  logic        fast;
  logic        rise;
  logic        fall;
  logic        cmd_busy;
  logic        rx_busy;

  sd_card_sequencer seq0 (
    .clk_100mhz, .reset_ah, .start_i, .sector_pos_i, .sector_count_i,
    .cmd_done_i(cmd_done), .resp_ok_i(resp_ok), .resp_bits_i(resp_bits),
    .data_done_i(data_done), .data_ok_i(data_ok),
    .cmd_start_o(cmd_start), .cmd_index_o(cmd_index), .cmd_arg_o(cmd_arg),
    .data_start_o(data_start), .fast_o(fast), .init_done_o, .run_done_o
  );

  sd_clock_gen #(.CLK_DIV_SLOW(CLK_DIV_SLOW), .CLK_DIV_FAST(CLK_DIV_FAST)) clk0 (
    .clk_100mhz, .reset_ah,
    .run_i(cmd_busy | rx_busy),  // bus clock only runs while someone needs it
    .fast_i(fast), .sdclk_o, .rise_o(rise), .fall_o(fall)
  );

  sd_cmd_engine #(.RESP_TIMEOUT(RESP_TIMEOUT)) cmd0 (
    .clk_100mhz, .reset_ah, .cmd_start_i(cmd_start), .cmd_index_i(cmd_index),
    .cmd_arg_i(cmd_arg), .rise_i(rise), .fall_i(fall), .cmd_i,
    .busy_o(cmd_busy), .cmd_o, .cmd_oe_o, .cmd_done_o(cmd_done),
    .resp_ok_o(resp_ok), .resp_bits_o(resp_bits)
  );

  sd_sector_rx #(.DATA_TIMEOUT(DATA_TIMEOUT)) rx0 (
    .clk_100mhz, .reset_ah, .data_start_i(data_start), .rise_i(rise), .fall_i(fall),
    .dat_i, .buf_addr_i, .busy_o(rx_busy), .data_done_o(data_done),
    .data_ok_o(data_ok), .sector_done_o, .buf_data_o
  );

endmodule

`default_nettype wire

// ==== sdio_burst_reader.f ====
logic/sd_bus_pkg.sv
logic/sd_cmd_pkg.sv
logic/sd_clock_gen.sv
logic/sd_cmd_engine.sv
logic/sd_card_sequencer.sv
logic/sd_sector_rx.sv
logic/sdio_burst_reader.sv
bench/sd_card_model.sv
bench/tb_sdio_burst_reader.sv
